// ==== dcache_pkg.sv ====
// Shared geometry, latencies, fault codes and controller state encodings
// Cache line union with data and fault views, boot-ROM line pattern
`default_nettype none

package dcache_pkg;

	// ============================================================
	// Geometry
	// ============================================================
	localparam int ADR_W      = 32;
	localparam int LINE_OFS_W = 6;
	localparam int BEAT_W     = 128;
	localparam int BEATS      = 4;
	localparam int DATA_W     = BEATS * BEAT_W;
	localparam int LINE_W     = 8 + DATA_W;
	localparam int LINE_BYTES = LINE_W / 8;
	localparam int L1_LINES   = 16;
	localparam int L2_LINES   = 64;
	localparam int L1_IDX_W   = $clog2(L1_LINES);
	localparam int L2_IDX_W   = $clog2(L2_LINES);
	localparam int L1_TAG_W   = ADR_W - LINE_OFS_W - L1_IDX_W;
	localparam int L2_TAG_W   = ADR_W - LINE_OFS_W - L2_IDX_W;

	// Latencies in cycles
	localparam int L2_READ_LAT  = 3;
	localparam int ROM_READ_LAT = 1;
	localparam int L1_WRITE_LAT = 3;

	// Upper address half that selects the boot ROM
	localparam logic [15:0] ROM_BASE = 16'h0001;

	// Fault codes
	localparam int FAULT_W = 3;
	localparam logic [FAULT_W-1:0] FAULT_NONE = 3'd0;
	localparam logic [FAULT_W-1:0] FAULT_RDV  = 3'd2;
	localparam logic [FAULT_W-1:0] FAULT_ERR  = 3'd3;

	// Refill FSM states
	localparam logic [2:0] ST_IDLE = 3'd0;
	localparam logic [2:0] ST_LAT  = 3'd1;
	localparam logic [2:0] ST_L2W  = 3'd2;
	localparam logic [2:0] ST_ACK  = 3'd3;
	localparam logic [2:0] ST_GAP  = 3'd4;
	localparam logic [2:0] ST_FILL = 3'd5;
	localparam logic [2:0] ST_WAIT = 3'd6;

	// One line word; top 3 bits non-zero marks a fault line
	typedef union packed {
		struct packed {
			logic [7:0] status;
			logic [BEATS-1:0][BEAT_W-1:0] beats;
		} data;
		struct packed {
			logic [FAULT_W-1:0] code;
			logic [LINE_W-FAULT_W-1:0] rsvd;
		} fault;
	} dc_line_u;

	// Boot-ROM contents: line address XOR word index times golden ratio
	function automatic logic [DATA_W-1:0] rom_line(input logic [ADR_W-1:0] adr);
		logic [DATA_W-1:0] d;
		logic [ADR_W-1:0] base;
		base = {adr[ADR_W-1:LINE_OFS_W], {LINE_OFS_W{1'b0}}};
		for (int w = 0; w < DATA_W / 32; w++)
			d[w*32 +: 32] = base ^ (32'(w) * 32'h9e37_79b9);
		return d;
	endfunction

endpackage

`default_nettype wire

// ==== dcache_rom.sv ====
// Boot-ROM line source, one-cycle registered read
`default_nettype none

module dcache_rom (
	input wire clk,
	input wire rst_i,
	input wire [dcache_pkg::ADR_W-1:0] adr_i,
	output logic [dcache_pkg::DATA_W-1:0] dat_o
);
	import dcache_pkg::*;

	// Pattern generated from the line address
	always_ff @(posedge clk) begin
		if (rst_i)
			dat_o <= '0;
		else
			dat_o <= rom_line(adr_i);
	end

endmodule

`default_nettype wire

// ==== dcache_l1.sv ====
// Direct-mapped L1 data array with valid bits and tags
// Byte-enable writes, single-line invalidate, combinational hit
`default_nettype none

module dcache_l1 (
	input wire clk,
	input wire rst_i,
	input wire [dcache_pkg::ADR_W-1:0] adr_i,
	input wire wr_i,
	input wire [dcache_pkg::LINE_BYTES-1:0] sel_i,
	input wire dcache_pkg::dc_line_u line_i,
	input wire inv_i,
	input wire [dcache_pkg::ADR_W-1:0] rd_adr_i,
	output logic hit_o,
	output dcache_pkg::dc_line_u rd_line_o
);
	import dcache_pkg::*;

	logic [LINE_W-1:0] lines_q [L1_LINES];
	logic [L1_TAG_W-1:0] tags_q [L1_LINES];
	logic [L1_LINES-1:0] valid_q;

	logic [L1_IDX_W-1:0] widx;
	logic [L1_IDX_W-1:0] ridx;
	logic [L1_TAG_W-1:0] wtag;
	logic [L1_TAG_W-1:0] rtag;
	logic full_wr;

	// Index sits just above the line offset, tag above that
	assign widx = adr_i[LINE_OFS_W +: L1_IDX_W];
	assign wtag = adr_i[ADR_W-1 -: L1_TAG_W];
	assign ridx = rd_adr_i[LINE_OFS_W +: L1_IDX_W];
	assign rtag = rd_adr_i[ADR_W-1 -: L1_TAG_W];

	// Refills write every byte including status
	assign full_wr = wr_i && (&sel_i);

	// ============================================================
	// Arrays
	// ============================================================
	always_ff @(posedge clk) begin
		if (wr_i) begin
			for (int b = 0; b < LINE_BYTES; b++)
				if (sel_i[b])
					lines_q[widx][b*8 +: 8] <= line_i[b*8 +: 8];
		end
		if (full_wr)
			tags_q[widx] <= wtag;
	end

	// Valid bits
	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_q <= '0;
		end else begin
			if (inv_i)
				valid_q[widx] <= 1'b0;
			else if (full_wr)
				valid_q[widx] <= 1'b1;
		end
	end

	// Lookup
	assign hit_o     = valid_q[ridx] && (tags_q[ridx] == rtag);
	assign rd_line_o = lines_q[ridx];

endmodule

`default_nettype wire

// ==== dcache_l2.sv ====
// Direct-mapped L2 array with a three-stage read pipeline
// Byte or full-line load, combinational store-address hit
`default_nettype none

module dcache_l2 (
	input wire clk,
	input wire rst_i,
	input wire [dcache_pkg::ADR_W-1:0] rd_adr_i,
	input wire ld_i,
	input wire [dcache_pkg::ADR_W-1:0] ld_adr_i,
	input wire [dcache_pkg::LINE_BYTES-1:0] sel_i,
	input wire dcache_pkg::dc_line_u line_i,
	input wire [dcache_pkg::ADR_W-1:0] wadr_i,
	output logic rhit_o,
	output dcache_pkg::dc_line_u rdat_o,
	output logic whit_o
);
	import dcache_pkg::*;

	logic [LINE_W-1:0] lines_q [L2_LINES];
	logic [L2_TAG_W-1:0] tags_q [L2_LINES];
	logic [L2_LINES-1:0] valid_q;

	logic [L2_IDX_W-1:0] lidx;
	logic [L2_IDX_W-1:0] widx;
	logic [L2_IDX_W-1:0] s1_idx;
	logic [ADR_W-1:0] s1_adr_q;
	logic s2_hit_q;
	logic [LINE_W-1:0] s2_line_q;

	assign lidx   = ld_adr_i[LINE_OFS_W +: L2_IDX_W];
	assign widx   = wadr_i[LINE_OFS_W +: L2_IDX_W];
	assign s1_idx = s1_adr_q[LINE_OFS_W +: L2_IDX_W];

	// ============================================================
	// Load port
	// ============================================================
	always_ff @(posedge clk) begin
		if (ld_i) begin
			for (int b = 0; b < LINE_BYTES; b++)
				if (sel_i[b])
					lines_q[lidx][b*8 +: 8] <= line_i[b*8 +: 8];
			if (&sel_i)
				tags_q[lidx] <= ld_adr_i[ADR_W-1 -: L2_TAG_W];
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i)
			valid_q <= '0;
		else if (ld_i && (&sel_i))
			valid_q[lidx] <= 1'b1;
	end

	// ============================================================
	// Read pipeline: address, lookup, output register
	// ============================================================
	always_ff @(posedge clk) begin
		s1_adr_q  <= rd_adr_i;
		s2_line_q <= lines_q[s1_idx];
		rdat_o    <= s2_line_q;
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			s2_hit_q <= 1'b0;
			rhit_o   <= 1'b0;
		end else begin
			s2_hit_q <= valid_q[s1_idx] &&
				(tags_q[s1_idx] == s1_adr_q[ADR_W-1 -: L2_TAG_W]);
			rhit_o   <= s2_hit_q;
		end
	end

	// Store hit, looked up directly on the store address
	assign whit_o = valid_q[widx] && (tags_q[widx] == wadr_i[ADR_W-1 -: L2_TAG_W]);

endmodule

`default_nettype wire

// ==== dcache_ctrl.sv ====
// Refill controller: miss handling via ROM, L2 or burst bus
// Store merge into L1 and L2, single-line invalidate, fill counter
`default_nettype none

module dcache_ctrl (
	input wire clk,
	input wire rst_i,
	// CPU side
	input wire rd_i,
	input wire [dcache_pkg::ADR_W-1:0] rd_adr_i,
	input wire wr_i,
	input wire [dcache_pkg::ADR_W-1:0] wr_adr_i,
	input wire [7:0] wr_sel_i,
	input wire [63:0] wr_dat_i,
	input wire inv_i,
	input wire [dcache_pkg::ADR_W-1:0] inv_adr_i,
	output logic done_o,
	output logic [31:0] fill_count_o,
	// L1 side
	input wire l1_hit_i,
	output logic [dcache_pkg::ADR_W-1:0] l1_adr_o,
	output logic l1_wr_o,
	output logic [dcache_pkg::LINE_BYTES-1:0] l1_sel_o,
	output dcache_pkg::dc_line_u l1_line_o,
	output logic l1_inv_o,
	// L2 side
	input wire l2_rhit_i,
	input wire l2_whit_i,
	input wire dcache_pkg::dc_line_u l2_rdat_i,
	output logic [dcache_pkg::ADR_W-1:0] l2_adr_o,
	output logic l2_ld_o,
	output logic [dcache_pkg::LINE_BYTES-1:0] l2_sel_o,
	output dcache_pkg::dc_line_u l2_line_o,
	// ROM side
	input wire [dcache_pkg::DATA_W-1:0] rom_dat_i,
	output logic [dcache_pkg::ADR_W-1:0] rom_adr_o,
	// Bus master
	output logic cyc_o,
	output logic stb_o,
	output logic [2:0] cti_o,
	output logic [15:0] sel_o,
	output logic [dcache_pkg::ADR_W-1:0] adr_o,
	input wire ack_i,
	input wire err_i,
	input wire rdv_i,
	input wire bok_i,
	input wire [dcache_pkg::BEAT_W-1:0] dat_i
);
	import dcache_pkg::*;

	logic [2:0] state_q;
	logic [2:0] cnt_q;
	logic [$clog2(BEATS)-1:0] beat_q;
	logic inv_pend_q;
	logic [ADR_W-1:0] inv_adr_q;
	logic [ADR_W-1:0] rd_line;
	logic [ADR_W-1:0] wr_line;
	logic [ADR_W-1:0] inv_line;
	logic is_rom;

	// Line-aligned versions of the request addresses
	assign rd_line  = {rd_adr_i[ADR_W-1:LINE_OFS_W], {LINE_OFS_W{1'b0}}};
	assign wr_line  = {wr_adr_i[ADR_W-1:LINE_OFS_W], {LINE_OFS_W{1'b0}}};
	assign inv_line = {inv_adr_q[ADR_W-1:LINE_OFS_W], {LINE_OFS_W{1'b0}}};

	// ROM region is decided on the latched miss address
	assign is_rom = l1_adr_o[ADR_W-1:16] == ROM_BASE;

	// L1 and L2 take the same line word and byte enables
	assign l2_line_o = l1_line_o;
	assign l2_sel_o  = l1_sel_o;
	assign rom_adr_o = l1_adr_o;

	// Close the bus cycle and go write the line
	task automatic end_burst();
		cyc_o   <= 1'b0;
		stb_o   <= 1'b0;
		cti_o   <= 3'b000;
		sel_o   <= 16'h0000;
		state_q <= ST_FILL;
	endtask

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q      <= ST_IDLE;
			cnt_q        <= '0;
			beat_q       <= '0;
			inv_pend_q   <= 1'b0;
			done_o       <= 1'b0;
			fill_count_o <= '0;
			l1_wr_o      <= 1'b0;
			l1_inv_o     <= 1'b0;
			l2_ld_o      <= 1'b0;
			cyc_o        <= 1'b0;
			stb_o        <= 1'b0;
			cti_o        <= 3'b000;
			sel_o        <= 16'h0000;
		end else begin
			// Strobes are single-cycle
			l1_wr_o  <= 1'b0;
			l1_inv_o <= 1'b0;
			l2_ld_o  <= 1'b0;
			done_o   <= 1'b0;

			case (state_q)
			// ============================================================
			// Idle: store, then invalidate, then miss
			// ============================================================
			ST_IDLE: begin
				cnt_q <= '0;
				if (wr_i) begin
					// Shift doubleword and enables into line position
					l1_adr_o  <= wr_line;
					l2_adr_o  <= wr_line;
					l1_line_o <= {8'h00,
						DATA_W'(wr_dat_i) << {wr_adr_i[LINE_OFS_W-1:3], 6'd0}};
					l1_sel_o  <= {1'b0,
						(DATA_W / 8)'(wr_sel_i) << {wr_adr_i[LINE_OFS_W-1:3], 3'd0}};
					// Each level updates only where it holds the line
					l1_wr_o   <= l1_hit_i;
					l2_ld_o   <= l2_whit_i;
				end else if (inv_pend_q) begin
					l1_adr_o   <= inv_line;
					l1_inv_o   <= 1'b1;
					inv_pend_q <= 1'b0;
				end else if (rd_i && !l1_hit_i) begin
					l1_adr_o <= rd_line;
					l2_adr_o <= rd_line;
					state_q  <= ST_LAT;
				end
			end
			// Count out ROM or L2 read latency
			ST_LAT: begin
				cnt_q <= cnt_q + 3'd1;
				if (is_rom) begin
					if (cnt_q == 3'(ROM_READ_LAT)) begin
						l1_line_o <= {8'h00, rom_dat_i};
						l1_sel_o  <= '1;
						l1_wr_o   <= 1'b1;
						cnt_q     <= '0;
						state_q   <= ST_WAIT;
					end
				end else if (cnt_q == 3'(L2_READ_LAT)) begin
					cnt_q   <= '0;
					state_q <= ST_L2W;
				end
			end
			// L2 result is valid here; on a miss go to the bus
			ST_L2W: begin
				l1_sel_o <= '1;
				if (l2_rhit_i) begin
					l1_line_o <= l2_rdat_i;
					l1_wr_o   <= 1'b1;
					state_q   <= ST_WAIT;
				end else begin
					l1_line_o <= '0;
					beat_q    <= '0;
					cyc_o     <= 1'b1;
					stb_o     <= 1'b1;
					cti_o     <= 3'b001;
					sel_o     <= 16'hffff;
					adr_o     <= l1_adr_o;
					state_q   <= ST_ACK;
				end
			end
			// ============================================================
			// Bus beats
			// ============================================================
			ST_ACK: begin
				if (ack_i || err_i || rdv_i) begin
					if (err_i || rdv_i) begin
						// Fault ends the burst with a fault line
						l1_line_o.fault.code <= err_i ? FAULT_ERR : FAULT_RDV;
						l1_line_o.fault.rsvd <= '0;
						end_burst();
					end else begin
						l1_line_o.data.beats[beat_q] <= dat_i;
						beat_q <= beat_q + 1'b1;
						if (beat_q == $bits(beat_q)'(BEATS - 1)) begin
							end_burst();
						end else begin
							if (beat_q == $bits(beat_q)'(BEATS - 2))
								cti_o <= 3'b111;
							// Single transfers: drop strobe, step address
							if (!bok_i) begin
								stb_o   <= 1'b0;
								adr_o   <= {adr_o[ADR_W-1:4] + 1'b1, 4'h0};
								state_q <= ST_GAP;
							end
						end
					end
				end
			end
			// Wait for the slave to release ack
			ST_GAP: begin
				if (!ack_i) begin
					stb_o   <= 1'b1;
					state_q <= ST_ACK;
				end
			end
			// Write the assembled line into both levels
			ST_FILL: begin
				l1_wr_o      <= 1'b1;
				l2_ld_o      <= 1'b1;
				fill_count_o <= fill_count_o + 32'd1;
				cnt_q        <= '0;
				state_q      <= ST_WAIT;
			end
			// L1 write latency before the CPU is released
			ST_WAIT: begin
				cnt_q <= cnt_q + 3'd1;
				if (cnt_q == 3'(L1_WRITE_LAT)) begin
					done_o  <= 1'b1;
					state_q <= ST_IDLE;
				end
			end
			default: state_q <= ST_IDLE;
			endcase

			// Latch late so a new request is never lost
			if (inv_i) begin
				inv_pend_q <= 1'b1;
				inv_adr_q  <= inv_adr_i;
			end
		end
	end

endmodule

`default_nettype wire

// ==== dcache_top.sv ====
// Data-cache refill subsystem top level
// Controller, L1, L2 and boot ROM; doubleword and fault select for the CPU
`default_nettype none

module dcache_top (
	input wire clk,
	input wire rst_i,
	// Load
	input wire rd_i,
	input wire [dcache_pkg::ADR_W-1:0] rd_adr_i,
	output logic hit_o,
	output logic [63:0] rd_dat_o,
	output logic [dcache_pkg::FAULT_W-1:0] rd_fault_o,
	// Store
	input wire wr_i,
	input wire [dcache_pkg::ADR_W-1:0] wr_adr_i,
	input wire [7:0] wr_sel_i,
	input wire [63:0] wr_dat_i,
	// Invalidate and status
	input wire inv_i,
	input wire [dcache_pkg::ADR_W-1:0] inv_adr_i,
	output logic done_o,
	output logic [31:0] fill_count_o,
	// Bus master
	output logic cyc_o,
	output logic stb_o,
	output logic [2:0] cti_o,
	output logic [15:0] sel_o,
	output logic [dcache_pkg::ADR_W-1:0] adr_o,
	input wire ack_i,
	input wire err_i,
	input wire rdv_i,
	input wire bok_i,
	input wire [dcache_pkg::BEAT_W-1:0] dat_i
);
	import dcache_pkg::*;

	logic [ADR_W-1:0] l1_adr;
	logic l1_wr;
	logic [LINE_BYTES-1:0] l1_sel;
	dc_line_u l1_line;
	logic l1_inv;
	logic l1_hit;
	dc_line_u l1_rdat;
	logic [ADR_W-1:0] l1_rd_adr;
	logic [ADR_W-1:0] l2_adr;
	logic l2_ld;
	logic [LINE_BYTES-1:0] l2_sel;
	dc_line_u l2_line;
	logic l2_rhit;
	logic l2_whit;
	dc_line_u l2_rdat;
	logic [ADR_W-1:0] rom_adr;
	logic [DATA_W-1:0] rom_dat;
	logic [BEAT_W-1:0] rd_beat;

	// Store lookup borrows the L1 read port
	assign l1_rd_adr = wr_i ? wr_adr_i : rd_adr_i;

	// ============================================================
	// CPU read data
	// ============================================================
	assign hit_o      = l1_hit && !wr_i;
	assign rd_fault_o = l1_rdat.fault.code;
	assign rd_beat    = l1_rdat.data.beats[l1_rd_adr[LINE_OFS_W-1:4]];

	// Fault lines carry no data
	always_comb begin
		if (rd_fault_o != FAULT_NONE)
			rd_dat_o = '0;
		else if (l1_rd_adr[3])
			rd_dat_o = rd_beat[127:64];
		else
			rd_dat_o = rd_beat[63:0];
	end

	dcache_ctrl u_ctrl (
		.clk(clk), .rst_i(rst_i),
		.rd_i(rd_i), .rd_adr_i(rd_adr_i),
		.wr_i(wr_i), .wr_adr_i(wr_adr_i), .wr_sel_i(wr_sel_i), .wr_dat_i(wr_dat_i),
		.inv_i(inv_i), .inv_adr_i(inv_adr_i),
		.done_o(done_o), .fill_count_o(fill_count_o),
		.l1_hit_i(l1_hit), .l1_adr_o(l1_adr), .l1_wr_o(l1_wr),
		.l1_sel_o(l1_sel), .l1_line_o(l1_line), .l1_inv_o(l1_inv),
		.l2_rhit_i(l2_rhit), .l2_whit_i(l2_whit), .l2_rdat_i(l2_rdat),
		.l2_adr_o(l2_adr), .l2_ld_o(l2_ld), .l2_sel_o(l2_sel), .l2_line_o(l2_line),
		.rom_dat_i(rom_dat), .rom_adr_o(rom_adr),
		.cyc_o(cyc_o), .stb_o(stb_o), .cti_o(cti_o), .sel_o(sel_o), .adr_o(adr_o),
		.ack_i(ack_i), .err_i(err_i), .rdv_i(rdv_i), .bok_i(bok_i), .dat_i(dat_i)
	);

	dcache_l1 u_l1 (
		.clk(clk), .rst_i(rst_i),
		.adr_i(l1_adr), .wr_i(l1_wr), .sel_i(l1_sel), .line_i(l1_line),
		.inv_i(l1_inv), .rd_adr_i(l1_rd_adr),
		.hit_o(l1_hit), .rd_line_o(l1_rdat)
	);

	// L2 reads and loads share the controller's address
	dcache_l2 u_l2 (
		.clk(clk), .rst_i(rst_i),
		.rd_adr_i(l2_adr), .ld_i(l2_ld), .ld_adr_i(l2_adr),
		.sel_i(l2_sel), .line_i(l2_line), .wadr_i(wr_adr_i),
		.rhit_o(l2_rhit), .rdat_o(l2_rdat), .whit_o(l2_whit)
	);

	dcache_rom u_rom (
		.clk(clk), .rst_i(rst_i),
		.adr_i(rom_adr), .dat_o(rom_dat)
	);

endmodule

`default_nettype wire

// ==== tb_clkgen.sv ====
// Testbench clock and reset generator
// Clock period of 20 units, reset held for 3 rising edges
`default_nettype none

module tb_clkgen (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #10 clk_o = ~clk_o;
	end

	// Release reset just after the third rising edge
	initial begin
		rst_o = 1'b1;
		repeat (3) @(posedge clk_o);
		#1 rst_o = 1'b0;
	end

endmodule

`default_nettype wire

// ==== tb_dcache.sv ====
// Data-cache refill testbench with random loads, stores and invalidates
// Burst bus slave with delays and faults, reference L1/L2 model, checks
`default_nettype none

module tb_dcache;
	import dcache_pkg::*;

	localparam int TMO = 300;
	localparam int N_OPS = 400;

	logic clk;
	logic rst;
	logic rd = 1'b0;
	logic [31:0] rd_adr = '0;
	logic hit;
	logic [63:0] rd_dat;
	logic [2:0] rd_fault;
	logic wr = 1'b0;
	logic [31:0] wr_adr = '0;
	logic [7:0] wr_sel = '0;
	logic [63:0] wr_dat = '0;
	logic inv = 1'b0;
	logic [31:0] inv_adr = '0;
	logic done;
	logic [31:0] fill_count;
	logic cyc;
	logic stb;
	logic [2:0] cti;
	logic [15:0] sel;
	logic [31:0] adr;
	logic ack = 1'b0;
	logic err = 1'b0;
	logic rdv = 1'b0;
	logic bok = 1'b0;
	logic [127:0] bus_dat = '0;

	integer seed = 32'h0fa6_ea20;
	integer bus_seed = 32'h0fa6_ea20;
	int errors = 0;
	int checks = 0;
	int bus_starts = 0;
	logic aborted = 1'b0;
	logic cyc_seen = 1'b0;

	// Reference images of both cache levels
	logic l1_v [16];
	logic [21:0] l1_t [16];
	logic [511:0] l1_d [16];
	logic [2:0] l1_c [16];
	logic l2_v [64];
	logic [19:0] l2_t [64];
	logic [511:0] l2_d [64];
	logic [2:0] l2_c [64];

	tb_clkgen u_clkgen (.clk_o(clk), .rst_o(rst));

	dcache_top UUT (
		.clk(clk), .rst_i(rst),
		.rd_i(rd), .rd_adr_i(rd_adr), .hit_o(hit), .rd_dat_o(rd_dat), .rd_fault_o(rd_fault),
		.wr_i(wr), .wr_adr_i(wr_adr), .wr_sel_i(wr_sel), .wr_dat_i(wr_dat),
		.inv_i(inv), .inv_adr_i(inv_adr), .done_o(done), .fill_count_o(fill_count),
		.cyc_o(cyc), .stb_o(stb), .cti_o(cti), .sel_o(sel), .adr_o(adr),
		.ack_i(ack), .err_i(err), .rdv_i(rdv), .bok_i(bok), .dat_i(bus_dat)
	);

	// ============================================================
	// Bus memory model
	// ============================================================
	// Each 32-bit word is its byte address XOR a fixed mask
	function automatic logic [127:0] beat_data(input logic [31:0] a);
		logic [127:0] d;
		for (int w = 0; w < 4; w++)
			d[w*32 +: 32] = (a + 32'(w * 4)) ^ 32'h5a5a_0000;
		return d;
	endfunction

	// Bits 11:8 of F give a bus error, E a read violation
	function automatic logic [2:0] bus_fault(input logic [31:0] a);
		if (a[11:8] == 4'hf)
			return FAULT_ERR;
		else if (a[11:8] == 4'he)
			return FAULT_RDV;
		return FAULT_NONE;
	endfunction

	int beat = 0;
	int dly = 0;
	logic [31:0] line_base;

	// Slave answers one beat at a time after a random delay
	always @(posedge clk) begin
		#1;
		if (ack || err || rdv) begin
			// Strobe stays up between beats only in burst mode
			if (ack && cyc)
				check_val("stb_o", 64'(stb), 64'(bok));
			ack = 1'b0;
			err = 1'b0;
			rdv = 1'b0;
			beat = beat + 1;
			dly = $random(bus_seed) & 3;
		end else if (cyc && stb) begin
			if (dly > 0) begin
				dly = dly - 1;
			end else begin
				line_base = {adr[31:6], 6'd0};
				check_val("sel_o", 64'(sel), 64'hffff);
				check_val("cti_o", 64'(cti), (beat == 3) ? 64'h7 : 64'h1);
				// Single transfers step the address one beat at a time
				if (!bok)
					check_val("adr_o", 64'(adr), 64'(line_base + 32'(beat * 16)));
				case (bus_fault(line_base))
					FAULT_ERR: err = 1'b1;
					FAULT_RDV: rdv = 1'b1;
					default: begin
						ack = 1'b1;
						bus_dat = beat_data(line_base + 32'(beat * 16));
					end
				endcase
			end
		end
		// New burst mode is picked between fills
		if (!cyc) begin
			beat = 0;
			bok = $random(bus_seed) & 1;
		end
	end

	// Count bus cycles by the rising edge of cyc_o
	always @(posedge clk) begin
		if (cyc && !cyc_seen)
			bus_starts = bus_starts + 1;
		cyc_seen = cyc;
	end

	// ============================================================
	// Checks and reference model
	// ============================================================
	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// Updates the model for a load and gives the line it must return
	task automatic model_load(input logic [31:0] a, output logic [2:0] code,
		output logic [511:0] line, output logic bus, output logic l1_hit);
		int i1;
		int i2;
		logic [31:0] base;
		base = {a[31:6], 6'd0};
		i1 = int'(a[9:6]);
		i2 = int'(a[11:6]);
		bus = 1'b0;
		l1_hit = l1_v[i1] && l1_t[i1] == a[31:10];
		if (!l1_hit) begin
			if (a[31:16] == ROM_BASE) begin
				// ROM refills go to L1 only
				l1_d[i1] = rom_line(base);
				l1_c[i1] = FAULT_NONE;
			end else if (l2_v[i2] && l2_t[i2] == a[31:12]) begin
				l1_d[i1] = l2_d[i2];
				l1_c[i1] = l2_c[i2];
			end else begin
				bus = 1'b1;
				l2_c[i2] = bus_fault(base);
				for (int b = 0; b < 4; b++)
					l2_d[i2][b*128 +: 128] = beat_data(base + 32'(b * 16));
				if (l2_c[i2] != FAULT_NONE)
					l2_d[i2] = '0;
				l2_v[i2] = 1'b1;
				l2_t[i2] = a[31:12];
				l1_d[i1] = l2_d[i2];
				l1_c[i1] = l2_c[i2];
			end
			l1_v[i1] = 1'b1;
			l1_t[i1] = a[31:10];
		end
		code = l1_c[i1];
		line = l1_d[i1];
	endtask

	task automatic load_and_check(input logic [31:0] a);
		logic [2:0] code;
		logic [511:0] line;
		logic bus;
		logic l1_hit;
		logic [63:0] exp;
		logic [31:0] fc0;
		int bs0;
		int n;
		model_load(a, code, line, bus, l1_hit);
		exp = (code != FAULT_NONE) ? 64'd0 : line[int'(a[5:3])*64 +: 64];
		@(posedge clk);
		#1;
		fc0 = fill_count;
		bs0 = bus_starts;
		rd = 1'b1;
		rd_adr = a;
		@(negedge clk);
		// Lookup answers in the request cycle
		check_val("hit_o", 64'(hit), 64'(l1_hit));
		if (!hit) begin
			n = 0;
			while (!done && n < TMO) begin
				@(negedge clk);
				n++;
			end
			if (!done) begin
				$display("Timeout: no done_o for load at address %h", a);
				errors++;
				aborted = 1'b1;
				return;
			end
			// Bus must be idle once the refill is over
			check_val("cyc_o", 64'(cyc), 64'd0);
			check_val("cti_o", 64'(cti), 64'd0);
			check_val("hit_o", 64'(hit), 64'd1);
			// Done is a single-cycle pulse
			@(negedge clk);
			check_val("done_o", 64'(done), 64'd0);
		end
		check_val("rd_dat_o", rd_dat, exp);
		check_val("rd_fault_o", 64'(rd_fault), 64'(code));
		check_val("fill_count_o", 64'(fill_count), 64'(fc0 + 32'(bus)));
		check_val("bus cycles", 64'(bus_starts - bs0), 64'(bus));
		@(posedge clk);
		#1 rd = 1'b0;
	endtask

	// Store merges enabled bytes into each level that holds the line
	task automatic store_and_merge(input logic [31:0] a, input logic [7:0] s,
		input logic [63:0] d);
		int i1;
		int i2;
		int p;
		i1 = int'(a[9:6]);
		i2 = int'(a[11:6]);
		for (int b = 0; b < 8; b++) begin
			p = int'(a[5:3]) * 8 + b;
			if (s[b] && l1_v[i1] && l1_t[i1] == a[31:10])
				l1_d[i1][p*8 +: 8] = d[b*8 +: 8];
			if (s[b] && l2_v[i2] && l2_t[i2] == a[31:12])
				l2_d[i2][p*8 +: 8] = d[b*8 +: 8];
		end
		@(posedge clk);
		#1;
		wr = 1'b1;
		wr_adr = a;
		wr_sel = s;
		wr_dat = d;
		@(posedge clk);
		#1 wr = 1'b0;
		repeat (2) @(posedge clk);
	endtask

	// Invalidate clears the L1 index whatever its tag
	task automatic invalidate_line(input logic [31:0] a);
		l1_v[int'(a[9:6])] = 1'b0;
		@(posedge clk);
		#1;
		inv = 1'b1;
		inv_adr = a;
		@(posedge clk);
		#1 inv = 1'b0;
		repeat (3) @(posedge clk);
	endtask

	// Mix of ROM and plain memory addresses over a few tags
	function automatic logic [31:0] rand_adr(input logic [31:0] r);
		if (r[1:0] == 2'd0)
			return {16'h0001, 4'd0, r[13:8], r[20:18], 3'b000};
		return {14'h0004, r[3:2], 3'd0, r[4], r[13:8], r[20:18], 3'b000};
	endfunction

	// ============================================================
	// Main sequence
	// ============================================================
	initial begin
		logic [31:0] r;
		int n;
		for (int i = 0; i < 16; i++)
			l1_v[i] = 1'b0;
		for (int i = 0; i < 64; i++)
			l2_v[i] = 1'b0;
		n = 0;
		while (rst !== 1'b0 && n < 50) begin
			@(posedge clk);
			n++;
		end
		if (rst !== 1'b0) begin
			$display("Timeout: reset never released");
			errors++;
			aborted = 1'b1;
		end
		if (!aborted) begin
			check_val("fill_count_o", 64'(fill_count), 64'd0);
			check_val("cyc_o", 64'(cyc), 64'd0);
			check_val("stb_o", 64'(stb), 64'd0);
			check_val("cti_o", 64'(cti), 64'd0);
			check_val("done_o", 64'(done), 64'd0);
			// Bus fill, then refill from L2 after invalidate
			load_and_check(32'h0010_0048);
			invalidate_line(32'h0010_0048);
			load_and_check(32'h0010_0070);
			// Boot ROM and both fault kinds
			load_and_check(32'h0001_0128);
			load_and_check(32'h0010_0f10);
			load_and_check(32'h0010_0e08);
		end
		for (int i = 0; i < N_OPS && !aborted; i++) begin
			r = $random(seed);
			if (r[31:30] != 2'd0 && r[29])
				load_and_check(rand_adr(r));
			else if (r[31:30] != 2'd0)
				store_and_merge(rand_adr(r), 8'($random(seed)),
					{32'($random(seed)), 32'($random(seed))});
			else
				invalidate_line(rand_adr(r));
		end
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dcache_top.f ====
dcache_pkg.sv
dcache_rom.sv
dcache_l1.sv
dcache_l2.sv
dcache_ctrl.sv
dcache_top.sv
tb_clkgen.sv
tb_dcache.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build and run the data-cache testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
	--top-module tb_dcache \
	-f dcache_top.f \
	--Mdir obj_dir \
	-o sim_dcache

./obj_dir/sim_dcache | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
	echo "Test failed"
	exit 1
fi

grep -q "Simulation finished: PASS" sim.log
echo "Test passed"
